// ==== sources.f ====
+incdir+source
source/memctl_pkg.sv
source/fetch_port.sv
source/data_port.sv
source/mem_control.sv
source/mem_subsystem.sv
dv/bus_model.sv
dv/tb_mem_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

LOG=sim.log
TOP=tb_mem_subsystem

rm -f "$LOG"

# a build error or an aborted run also counts as a failure in the log.
verilator --binary --timing --assert \
    --top-module "$TOP" -f sources.f -o "$TOP" > "$LOG" 2>&1 \
    && ./obj_dir/"$TOP" >> "$LOG" 2>&1 \
    || echo "TEST FAIL (build or simulation stopped with an error)" >> "$LOG"

cat "$LOG"

grep -q "TEST FAIL" "$LOG" \
    && { echo "simulation failed, see $LOG"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// ==== dv/tb_mem_subsystem.sv ====
`timescale 1ns/10ps

`include "memctl_consts.svh"

module tb_mem_subsystem;

    logic                      clk;
    logic                      rst;
    logic                      fetch_start;
    logic [`MEMCTL_ADDR_W-1:0] fetch_addr;
    logic [`MEMCTL_DATA_W-1:0] instr;
    logic                      instr_valid;
    logic                      fetch_busy;
    logic                      mem_read;
    logic                      mem_write;
    logic [`MEMCTL_ADDR_W-1:0] data_addr;
    logic [`MEMCTL_DATA_W-1:0] data_wdata;
    logic [`MEMCTL_DATA_W-1:0] data_rdata;
    logic                      data_valid;
    logic                      data_err;
    logic                      data_busy;
    logic [`MEMCTL_ADDR_W-1:0] bus_addr;
    logic [`MEMCTL_DATA_W-1:0] bus_wdata;
    logic                      bus_rd;
    logic                      bus_wr;
    logic [`MEMCTL_DATA_W-1:0] bus_rdata;
    logic                      bus_full;
    logic                      random_full;
    memctl_pkg::state_t        state;

    // expected values and check enables, set by the stimulus.
    string       test_name;
    logic [31:0] exp_instr;
    logic [31:0] exp_rdata;
    logic [31:0] exp_addr;
    logic [31:0] exp_wdata;
    logic [31:0] mem_word;
    logic        reset_chk;
    logic        store_chk;
    logic        pair_chk;
    logic        data_seen;
    logic        misalign_on;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    integer      seed;

    mem_subsystem DUT (.*);

    bus_model u_bus (.*);

    assign mem_word = u_bus.mem[exp_addr[9:2]];

    always #20 clk = ~clk;

    task automatic report_value(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
        errors++;
    endtask

    task automatic report_event(input string msg);
        $display("%s: %s", test_name, msg);
        errors++;
    endtask

    // ======================================================================
    // checks
    // ======================================================================

    a_reset_state: assert property (@(posedge clk) disable iff (rst)
        reset_chk |-> state == memctl_pkg::ST_IDLE)
        else report_value("state", 32'(memctl_pkg::ST_IDLE), 32'($sampled(state)));

    a_reset_busy: assert property (@(posedge clk) disable iff (rst)
        reset_chk |-> !fetch_busy && !data_busy)
        else report_value("busy", 0, 32'({$sampled(fetch_busy), $sampled(data_busy)}));

    a_reset_instr: assert property (@(posedge clk) disable iff (rst)
        reset_chk |-> instr == `MEMCTL_FETCH_RESET)
        else report_value("instr", `MEMCTL_FETCH_RESET, $sampled(instr));

    a_instr: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> instr == exp_instr)
        else report_value("instr", $sampled(exp_instr), $sampled(instr));

    // a store leaves data_rdata alone, so it must still hold the last load.
    a_load: assert property (@(posedge clk) disable iff (rst)
        data_valid |-> data_rdata == exp_rdata)
        else report_value("data_rdata", $sampled(exp_rdata), $sampled(data_rdata));

    a_store_mem: assert property (@(posedge clk) disable iff (rst)
        data_valid && store_chk |-> mem_word == exp_wdata)
        else report_value("memory word", $sampled(exp_wdata), $sampled(mem_word));

    a_pair_order: assert property (@(posedge clk) disable iff (rst)
        instr_valid && pair_chk |-> data_valid || data_seen)
        else report_event("instr_valid arrived before data_valid");

    // the controller leaves its request state only after the bus had room.
    a_room: assert property (@(posedge clk) disable iff (rst)
        (bus_rd || bus_wr) |-> !$past(bus_full))
        else report_event("a bus strobe started although bus_full was high");

    a_err_expected: assert property (@(posedge clk) disable iff (rst)
        data_err |-> misalign_on)
        else report_event("data_err pulsed without a misaligned request");

    a_misalign_quiet: assert property (@(posedge clk) disable iff (rst)
        misalign_on |-> !bus_rd && !data_busy && !data_valid)
        else report_value("bus_rd, data_busy, data_valid", 0,
                          32'({$sampled(bus_rd), $sampled(data_busy), $sampled(data_valid)}));

    // ======================================================================
    // stimulus
    // ======================================================================

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("test %-14s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %-14s failed with %0d errors", test_name, errors - test_errors);
        end
    endtask

    task automatic set_store(input logic [31:0] addr, input logic [31:0] word);
        exp_addr   = addr;
        exp_wdata  = word;
        store_chk  = 1'b1;
        data_addr  = addr;
        data_wdata = word;
        mem_write  = 1'b1;
    endtask

    task automatic set_load(input logic [31:0] addr, input logic [31:0] word);
        exp_rdata = word;
        store_chk = 1'b0;
        data_addr = addr;
        mem_read  = 1'b1;
    endtask

    task automatic set_fetch(input logic [31:0] addr, input logic [31:0] word);
        exp_instr   = word;
        fetch_addr  = addr;
        fetch_start = 1'b1;
    endtask

    task automatic strobe_cycle();
        @(posedge clk);
        #2;
        fetch_start = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
    endtask

    // want holds {data_err, instr_valid, data_valid}.
    task automatic wait_pulses(input logic [2:0] want);
        logic [2:0] seen;
        int         cycles;
        seen   = {data_err, instr_valid, data_valid};
        cycles = 0;
        while ((seen & want) != want && cycles < 50) begin
            @(posedge clk);
            #2;
            cycles++;
            seen      = seen | {data_err, instr_valid, data_valid};
            data_seen = data_seen || data_valid;
        end
        if ((seen & want) != want) begin
            report_event("no valid or error pulse arrived within 50 cycles");
        end
        // the checks sample the last pulse on this edge.
        @(posedge clk);
        #2;
    endtask

    initial begin
        int          slot;
        int          draw;
        logic [31:0] word;
        logic [31:0] shadow [0:7];
        logic        written [0:7];
        clk          = 1'b0;
        rst          = 1'b1;
        fetch_start  = 1'b0;
        fetch_addr   = '0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        data_addr    = '0;
        data_wdata   = '0;
        random_full  = 1'b0;
        exp_instr    = `MEMCTL_FETCH_RESET;
        exp_rdata    = '0;
        exp_addr     = '0;
        exp_wdata    = '0;
        reset_chk    = 1'b0;
        store_chk    = 1'b0;
        pair_chk     = 1'b0;
        data_seen    = 1'b0;
        misalign_on  = 1'b0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        seed         = 32'hea7a;
        test_name    = "reset";
        for (int i = 0; i < 8; i++) begin
            written[i] = 1'b0;
        end

        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;

        begin_test("reset_state");
        reset_chk = 1'b1;
        @(posedge clk);
        #2;
        reset_chk = 1'b0;
        end_test();

        begin_test("store_load");
        set_store(32'h40, 32'hdead_beef);
        strobe_cycle();
        wait_pulses(3'b001);
        set_load(32'h40, 32'hdead_beef);
        strobe_cycle();
        wait_pulses(3'b001);
        end_test();

        begin_test("fetch");
        set_store(32'hc0, 32'h00a0_0093);
        strobe_cycle();
        wait_pulses(3'b001);
        set_fetch(32'hc0, 32'h00a0_0093);
        strobe_cycle();
        wait_pulses(3'b010);
        end_test();

        begin_test("contention");
        set_store(32'hc4, 32'h0010_8113);
        strobe_cycle();
        wait_pulses(3'b001);
        set_store(32'h140, 32'h5a5a_1234);
        strobe_cycle();
        wait_pulses(3'b001);
        data_seen = 1'b0;
        pair_chk  = 1'b1;
        set_fetch(32'hc4, 32'h0010_8113);
        set_load(32'h140, 32'h5a5a_1234);
        strobe_cycle();
        wait_pulses(3'b011);
        pair_chk = 1'b0;
        end_test();

        begin_test("back_pressure");
        random_full = 1'b1;
        for (int n = 0; n < 24; n++) begin
            draw = $random(seed);
            slot = draw & 7;
            if (draw[3] || !written[slot]) begin
                word          = $random(seed);
                shadow[slot]  = word;
                written[slot] = 1'b1;
                set_store(32'h100 + slot * 4, word);
            end else begin
                set_load(32'h100 + slot * 4, shadow[slot]);
            end
            strobe_cycle();
            wait_pulses(3'b001);
        end
        random_full = 1'b0;
        end_test();

        begin_test("misalign");
        misalign_on = 1'b1;
        data_addr   = 32'h42;
        mem_read    = 1'b1;
        strobe_cycle();
        wait_pulses(3'b100);
        repeat (4) begin
            @(posedge clk);
            #2;
        end
        misalign_on = 1'b0;
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== dv/bus_model.sv ====
`timescale 1ns/10ps

`include "memctl_consts.svh"

module bus_model (
    input  logic                      clk,
    input  logic                      random_full,
    input  logic [`MEMCTL_ADDR_W-1:0] bus_addr,
    input  logic [`MEMCTL_DATA_W-1:0] bus_wdata,
    input  logic                      bus_rd,
    input  logic                      bus_wr,
    output logic [`MEMCTL_DATA_W-1:0] bus_rdata,
    output logic                      bus_full
);

    logic [`MEMCTL_DATA_W-1:0] mem [0:255];
    integer                    seed;

    // only 256 words are decoded, so the upper address bits alias.
    assign bus_rdata = bus_rd ? mem[bus_addr[9:2]] : '0;

    initial begin
        logic [31:0] draw;
        seed     = 32'hea7a;
        bus_full = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
        end
        forever begin
            @(posedge clk);
            if (bus_wr) begin
                mem[bus_addr[9:2]] = bus_wdata;
            end
            #2;
            draw     = $random(seed);
            bus_full = random_full && draw[0];
        end
    end

endmodule

// ==== source/mem_subsystem.sv ====
`timescale 1ns/10ps

`include "memctl_consts.svh"

module mem_subsystem (
    input  logic                      clk,
    input  logic                      rst,
    // fetch side of the core.
    input  logic                      fetch_start,
    input  logic [`MEMCTL_ADDR_W-1:0] fetch_addr,
    output logic [`MEMCTL_DATA_W-1:0] instr,
    output logic                      instr_valid,
    output logic                      fetch_busy,
    // load/store side of the core.
    input  logic                      mem_read,
    input  logic                      mem_write,
    input  logic [`MEMCTL_ADDR_W-1:0] data_addr,
    input  logic [`MEMCTL_DATA_W-1:0] data_wdata,
    output logic [`MEMCTL_DATA_W-1:0] data_rdata,
    output logic                      data_valid,
    output logic                      data_err,
    output logic                      data_busy,
    // external bus.
    output logic [`MEMCTL_ADDR_W-1:0] bus_addr,
    output logic [`MEMCTL_DATA_W-1:0] bus_wdata,
    output logic                      bus_rd,
    output logic                      bus_wr,
    input  logic [`MEMCTL_DATA_W-1:0] bus_rdata,
    input  logic                      bus_full,
    output memctl_pkg::state_t        state
);

    logic                      fetch_req;
    logic                      fetch_done;
    logic [`MEMCTL_ADDR_W-1:0] fetch_req_addr;
    logic                      data_req;
    logic                      data_done;
    memctl_pkg::mem_op_t       data_op;
    logic [`MEMCTL_ADDR_W-1:0] data_req_addr;
    logic [`MEMCTL_DATA_W-1:0] data_req_wdata;
    logic [`MEMCTL_DATA_W-1:0] rdata;

    fetch_port u_fetch_port (
        .clk         (clk),
        .rst         (rst),
        .fetch_start (fetch_start),
        .fetch_addr  (fetch_addr),
        .fetch_done  (fetch_done),
        .rdata       (rdata),
        .fetch_req   (fetch_req),
        .req_addr    (fetch_req_addr),
        .instr       (instr),
        .instr_valid (instr_valid),
        .fetch_busy  (fetch_busy)
    );

    data_port u_data_port (
        .clk        (clk),
        .rst        (rst),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_done  (data_done),
        .rdata      (rdata),
        .data_req   (data_req),
        .data_op    (data_op),
        .req_addr   (data_req_addr),
        .wdata      (data_req_wdata),
        .data_rdata (data_rdata),
        .data_valid (data_valid),
        .data_err   (data_err),
        .data_busy  (data_busy)
    );

    mem_control u_mem_control (
        .clk        (clk),
        .rst        (rst),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_req_addr),
        .data_req   (data_req),
        .data_op    (data_op),
        .data_addr  (data_req_addr),
        .data_wdata (data_req_wdata),
        .bus_full   (bus_full),
        .bus_rdata  (bus_rdata),
        .fetch_done (fetch_done),
        .data_done  (data_done),
        .rdata      (rdata),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_rd     (bus_rd),
        .bus_wr     (bus_wr),
        .state      (state)
    );

endmodule

// ==== source/mem_control.sv ====
`timescale 1ns/10ps

`include "memctl_consts.svh"

module mem_control (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fetch_req,
    input  logic [`MEMCTL_ADDR_W-1:0] fetch_addr,
    input  logic                      data_req,
    input  memctl_pkg::mem_op_t       data_op,
    input  logic [`MEMCTL_ADDR_W-1:0] data_addr,
    input  logic [`MEMCTL_DATA_W-1:0] data_wdata,
    input  logic                      bus_full,
    input  logic [`MEMCTL_DATA_W-1:0] bus_rdata,
    output logic                      fetch_done,
    output logic                      data_done,
    output logic [`MEMCTL_DATA_W-1:0] rdata,
    output logic [`MEMCTL_ADDR_W-1:0] bus_addr,
    output logic [`MEMCTL_DATA_W-1:0] bus_wdata,
    output logic                      bus_rd,
    output logic                      bus_wr,
    output memctl_pkg::state_t        state
);

    memctl_pkg::state_t  next_state;
    memctl_pkg::mem_op_t pend_op;
    logic                src_data;
    logic                xfer;

    // ==================================================================
    // state and pending operation
    // ==================================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= memctl_pkg::ST_INIT;
            pend_op  <= memctl_pkg::OP_NONE;
            src_data <= 1'b0;
        end else begin
            state <= next_state;
            // the winner is frozen here and stays until the next idle.
            if (state == memctl_pkg::ST_IDLE) begin
                if (data_req) begin
                    pend_op  <= data_op;
                    src_data <= 1'b1;
                end else if (fetch_req) begin
                    pend_op  <= memctl_pkg::OP_FETCH;
                    src_data <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            memctl_pkg::ST_INIT: begin
                next_state = memctl_pkg::ST_IDLE;
            end
            memctl_pkg::ST_IDLE: begin
                // data wins over fetch.
                if (data_req) begin
                    if (data_op == memctl_pkg::OP_STORE) begin
                        next_state = memctl_pkg::ST_WRITE_REQ;
                    end else begin
                        next_state = memctl_pkg::ST_READ_REQ;
                    end
                end else if (fetch_req) begin
                    next_state = memctl_pkg::ST_READ_REQ;
                end
            end
            memctl_pkg::ST_READ_REQ: begin
                next_state = bus_full ? memctl_pkg::ST_WAIT : memctl_pkg::ST_READ;
            end
            memctl_pkg::ST_WRITE_REQ: begin
                next_state = bus_full ? memctl_pkg::ST_WAIT : memctl_pkg::ST_WRITE;
            end
            memctl_pkg::ST_WAIT: begin
                if (!bus_full) begin
                    if (pend_op == memctl_pkg::OP_STORE) begin
                        next_state = memctl_pkg::ST_WRITE;
                    end else begin
                        next_state = memctl_pkg::ST_READ;
                    end
                end
            end
            memctl_pkg::ST_READ,
            memctl_pkg::ST_WRITE: begin
                next_state = memctl_pkg::ST_IDLE;
            end
            default: begin
                next_state = memctl_pkg::ST_IDLE;
            end
        endcase
    end

    // ==================================================================
    // bus side
    // ==================================================================

    assign bus_rd = (state == memctl_pkg::ST_READ);
    assign bus_wr = (state == memctl_pkg::ST_WRITE);
    assign xfer   = bus_rd || bus_wr;

    always_comb begin
        bus_addr  = '0;
        bus_wdata = '0;
        if (xfer) begin
            bus_addr = src_data ? data_addr : fetch_addr;
        end
        if (bus_wr) begin
            bus_wdata = data_wdata;
        end
    end

    // done goes out in the transfer cycle itself.
    assign data_done  = xfer && src_data;
    assign fetch_done = xfer && !src_data;

    // the bus only holds its read data while bus_rd is high.
    always_ff @(posedge clk) begin
        if (bus_rd) begin
            rdata <= bus_rdata;
        end
    end

    // ==================================================================
    // checks
    // ==================================================================

    // a store goes out as a write and everything else as a read.
    a_bus_op_kind: assert property (@(posedge clk) disable iff (rst)
        (bus_rd || bus_wr) |-> (bus_wr == (pend_op == memctl_pkg::OP_STORE)));

    a_done_to_requester: assert property (@(posedge clk) disable iff (rst)
        (!fetch_done || fetch_req) && (!data_done || data_req));

    // a transfer must wait until the bus has room.
    a_strobe_after_room: assert property (@(posedge clk) disable iff (rst)
        (bus_rd || bus_wr) |-> !$past(bus_full));

endmodule

// ==== source/data_port.sv ====
`timescale 1ns/10ps

`include "memctl_consts.svh"

module data_port (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      mem_read,
    input  logic                      mem_write,
    input  logic [`MEMCTL_ADDR_W-1:0] data_addr,
    input  logic [`MEMCTL_DATA_W-1:0] data_wdata,
    input  logic                      data_done,
    input  logic [`MEMCTL_DATA_W-1:0] rdata,
    output logic                      data_req,
    output memctl_pkg::mem_op_t       data_op,
    output logic [`MEMCTL_ADDR_W-1:0] req_addr,
    output logic [`MEMCTL_DATA_W-1:0] wdata,
    output logic [`MEMCTL_DATA_W-1:0] data_rdata,
    output logic                      data_valid,
    output logic                      data_err,
    output logic                      data_busy
);

    logic strobe;
    logic aligned;
    logic accept;
    logic start_q;
    logic capture;

    assign strobe    = mem_read || mem_write;
    assign aligned   = (data_addr[1:0] == 2'b00);
    assign accept    = strobe && !data_busy && aligned;
    assign data_busy = start_q || data_req || capture;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_q    <= 1'b0;
            data_req   <= 1'b0;
            capture    <= 1'b0;
            data_valid <= 1'b0;
            data_err   <= 1'b0;
            data_op    <= memctl_pkg::OP_NONE;
            data_rdata <= '0;
        end else begin
            start_q    <= accept;
            data_valid <= 1'b0;

            // misaligned words never reach the controller.
            data_err <= strobe && !data_busy && !aligned;

            if (accept) begin
                data_op <= mem_write ? memctl_pkg::OP_STORE : memctl_pkg::OP_LOAD;
            end

            if (start_q) begin
                data_req <= 1'b1;
            end else if (data_done) begin
                data_req <= 1'b0;
            end

            capture <= data_req && data_done;
            if (capture) begin
                data_valid <= 1'b1;
                if (data_op == memctl_pkg::OP_LOAD) begin
                    data_rdata <= rdata;
                end
                data_op <= memctl_pkg::OP_NONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= data_addr;
            wdata    <= data_wdata;
        end
    end

    // the core decodes one memory instruction at a time.
    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write));

endmodule

// ==== source/fetch_port.sv ====
`timescale 1ns/10ps

`include "memctl_consts.svh"

module fetch_port (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fetch_start,
    input  logic [`MEMCTL_ADDR_W-1:0] fetch_addr,
    input  logic                      fetch_done,
    input  logic [`MEMCTL_DATA_W-1:0] rdata,
    output logic                      fetch_req,
    output logic [`MEMCTL_ADDR_W-1:0] req_addr,
    output logic [`MEMCTL_DATA_W-1:0] instr,
    output logic                      instr_valid,
    output logic                      fetch_busy
);

    logic accept;
    logic start_q;
    logic capture;

    // a new fetch is taken only when nothing is in flight.
    assign accept     = fetch_start && !fetch_busy;
    assign fetch_busy = start_q || fetch_req || capture;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_q     <= 1'b0;
            fetch_req   <= 1'b0;
            capture     <= 1'b0;
            instr_valid <= 1'b0;
            instr       <= `MEMCTL_FETCH_RESET;
        end else begin
            start_q     <= accept;
            instr_valid <= 1'b0;

            // the request rises one cycle after the strobe was latched.
            if (start_q) begin
                fetch_req <= 1'b1;
            end else if (fetch_done) begin
                fetch_req <= 1'b0;
            end

            // the controller registers rdata on the done edge, so the word
            // is taken one cycle later.
            capture <= fetch_req && fetch_done;
            if (capture) begin
                instr       <= rdata;
                instr_valid <= 1'b1;
            end
        end
    end

    // held stable from the strobe until the request completes.
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= fetch_addr;
        end
    end

endmodule

// ==== source/memctl_pkg.sv ====
package memctl_pkg;

    // ==================================================================
    // controller states
    // ==================================================================

    typedef enum logic [2:0] {
        ST_INIT      = 3'd0,
        ST_IDLE      = 3'd1,
        ST_READ_REQ  = 3'd2,
        ST_WRITE_REQ = 3'd3,
        ST_READ      = 3'd4,
        ST_WRITE     = 3'd5,
        ST_WAIT      = 3'd6
    } state_t;

    // ==================================================================
    // request opcodes
    // ==================================================================

    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2,
        OP_FETCH = 2'd3
    } mem_op_t;

endpackage

// ==== source/memctl_consts.svh ====
`ifndef MEMCTL_CONSTS_SVH
`define MEMCTL_CONSTS_SVH

// ======================================================================
// bus and word sizes
// ======================================================================

// byte address width seen by both ports and the bus.
`define MEMCTL_ADDR_W 32

// every transfer is one full word.
`define MEMCTL_DATA_W 32

// ======================================================================
// reset values
// ======================================================================

// a harmless instruction (addi x0, x0, 0) so the core decodes a nop
// before the first fetch completes.
`define MEMCTL_FETCH_RESET 32'h0000_0013

`endif
